// File: Makefile
TOP := tb_expander_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --top-module $(TOP) -f compile.f --Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q "Simulation failed" sim.log; then echo "FAIL"; exit 1; fi
	@grep -q "Simulation completed successfully" sim.log
	@echo "PASS"

clean:
	rm -rf obj_dir sim.log

// File: compile.f
src/expander_pkg.sv
src/hold_filter.sv
src/pattern_sequencer.sv
src/i2c_bit_engine.sv
src/expander_write_ctrl.sv
src/expander_top.sv
verif/i2c_target_model.sv
verif/tb_expander_top.sv

// File: src/expander_pkg.sv
package expander_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [2:0] led_t;
	typedef logic [1:0] pat_idx_t;
	typedef logic [1:0] phase_t; // four phases per bus bit

	// first byte of a transfer is built from fields and sent as a plain byte
	typedef union packed
	{
		byte_t raw;
		struct packed
		{
			logic [6:0] addr;
			logic rw;
		} hdr;
	} i2c_byte_u;

	typedef enum logic [1:0]
	{
		op_start,
		op_byte,
		op_stop
	} bus_op_e;

	localparam byte_t CMD_CONFIG = 8'h03; // pin direction register
	localparam byte_t CMD_OUTPUT = 8'h01; // output port register
	localparam byte_t CONFIG_DATA = 8'h00; // all pins as outputs
	localparam logic RW_WRITE = 1'b0;

	localparam int PAT_COUNT = 3;
	localparam byte_t PAT_DATA [PAT_COUNT] = '{8'h01, 8'h03, 8'h07};

endpackage

// File: src/expander_top.sv
`timescale 1ns/10ps

module expander_top #(
	parameter int EN_HOLD = 511,
	parameter int BUTTON_HOLD = 511,
	parameter logic [6:0] TARGET_ADDR = 7'h20
) (
	input logic clk,
	input logic rst,
	input logic en,
	input logic button,
	output logic scl,
	output expander_pkg::led_t led,
	output logic nack_seen,
	inout wire sda
);

	import expander_pkg::*;

	logic en_fire;
	logic button_fire;
	byte_t pattern;
	logic op_go;
	logic op_ready;
	logic op_done;
	logic ack_ok;
	bus_op_e op_kind;
	i2c_byte_u op_byte;

	hold_filter #(
		.HOLD_CYCLES(EN_HOLD)
	) u_en_filter (
		.clk(clk),
		.rst(rst),
		.level(en),
		.fire(en_fire)
	);

	hold_filter #(
		.HOLD_CYCLES(BUTTON_HOLD)
	) u_button_filter (
		.clk(clk),
		.rst(rst),
		.level(button),
		.fire(button_fire)
	);

	pattern_sequencer u_pattern_sequencer (
		.clk(clk),
		.rst(rst),
		.step(button_fire),
		.led(led),
		.pattern(pattern)
	);

	expander_write_ctrl #(
		.TARGET_ADDR(TARGET_ADDR)
	) u_write_ctrl (
		.clk(clk),
		.rst(rst),
		.start(en_fire),
		.pattern(pattern),
		.op_ready(op_ready),
		.op_done(op_done),
		.ack_ok(ack_ok),
		.op_go(op_go),
		.op_kind(op_kind),
		.op_byte(op_byte),
		.nack_seen(nack_seen)
	);

	i2c_bit_engine u_bit_engine (
		.clk(clk),
		.rst(rst),
		.op_go(op_go),
		.op_kind(op_kind),
		.op_byte(op_byte),
		.op_ready(op_ready),
		.op_done(op_done),
		.ack_ok(ack_ok),
		.scl(scl),
		.sda(sda)
	);

endmodule

// File: src/expander_write_ctrl.sv
`timescale 1ns/10ps

module expander_write_ctrl #(
	parameter logic [6:0] TARGET_ADDR = 7'h20
) (
	input logic clk,
	input logic rst,
	input logic start,
	input expander_pkg::byte_t pattern,
	input logic op_ready,
	input logic op_done,
	input logic ack_ok,
	output logic op_go,
	output expander_pkg::bus_op_e op_kind,
	output expander_pkg::i2c_byte_u op_byte,
	output logic nack_seen
);

	import expander_pkg::*;

	localparam logic [2:0] ST_IDLE = 3'd0;
	localparam logic [2:0] ST_START = 3'd1;
	localparam logic [2:0] ST_ADDR = 3'd2;
	localparam logic [2:0] ST_CMD = 3'd3;
	localparam logic [2:0] ST_DATA = 3'd4;
	localparam logic [2:0] ST_STOP = 3'd5;

	logic [2:0] state;
	logic configured;
	byte_t pat_q;
	i2c_byte_u addr_byte;
	byte_t cmd_byte;
	byte_t data_byte;

	always_comb
	begin
		addr_byte.hdr.addr = TARGET_ADDR;
		addr_byte.hdr.rw = RW_WRITE;
		cmd_byte = configured ? CMD_OUTPUT : CMD_CONFIG;
		data_byte = configured ? pat_q : CONFIG_DATA;
	end

	// operation for the current state is valid whenever op_go is high
	always_comb
	begin
		op_kind = expander_pkg::op_byte;
		op_byte = addr_byte;
		case (state)
			ST_START:
				op_kind = op_start;
			ST_CMD:
				op_byte.raw = cmd_byte;
			ST_DATA:
				op_byte.raw = data_byte;
			ST_STOP:
				op_kind = op_stop;
			default:
				op_byte = addr_byte;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (state == ST_IDLE && start)
			pat_q <= pattern;
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= ST_IDLE;
			configured <= 1'b0;
			nack_seen <= 1'b0;
			op_go <= 1'b0;
		end
		else
		begin
			op_go <= 1'b0;
			if (state == ST_IDLE)
			begin
				if (start && op_ready)
				begin
					state <= ST_START;
					op_go <= 1'b1;
					nack_seen <= 1'b0;
				end
			end
			else if (op_done)
			begin
				if (state != ST_START && state != ST_STOP && !ack_ok)
				begin
					state <= ST_IDLE; // abandoned without a stop
					nack_seen <= 1'b1;
				end
				else if (state == ST_STOP)
				begin
					state <= ST_IDLE;
					configured <= 1'b1;
				end
				else
				begin
					state <= state + 3'd1;
					op_go <= 1'b1;
				end
			end
		end
	end

endmodule

// File: src/hold_filter.sv
`timescale 1ns/10ps

module hold_filter #(
	parameter int HOLD_CYCLES = 511
) (
	input logic clk,
	input logic rst,
	input logic level,
	output logic fire
);

	localparam int CNT_W = (HOLD_CYCLES > 1) ? $clog2(HOLD_CYCLES) : 1;

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			cnt <= '0;
			fire <= 1'b0;
		end
		else if (!level)
		begin
			cnt <= '0; // any low cycle restarts the hold
			fire <= 1'b0;
		end
		else if (cnt == CNT_W'(HOLD_CYCLES - 1))
		begin
			cnt <= '0; // count again while still held
			fire <= 1'b1;
		end
		else
		begin
			cnt <= cnt + 1'b1;
			fire <= 1'b0;
		end
	end

endmodule

// File: src/i2c_bit_engine.sv
`timescale 1ns/10ps

module i2c_bit_engine (
	input logic clk,
	input logic rst,
	input logic op_go,
	input expander_pkg::bus_op_e op_kind,
	input expander_pkg::i2c_byte_u op_byte,
	output logic op_ready,
	output logic op_done,
	output logic ack_ok,
	output logic scl,
	inout wire sda
);

	import expander_pkg::*;

	bus_op_e kind_q;
	phase_t phase;
	logic [3:0] bit_cnt; // 8 is the ack bit
	byte_t shreg;
	logic sda_oe;
	logic sda_out;
	logic is_byte;
	logic last;
	bus_op_e nxt_kind;
	phase_t nxt_phase;
	logic nxt_ack;
	logic nxt_bit;
	logic nxt_scl;
	logic nxt_oe;
	logic nxt_sda;

	assign sda = sda_oe ? sda_out : 1'bz;

	assign is_byte = (kind_q == expander_pkg::op_byte);
	assign last = (phase == 2'd3) && (!is_byte || bit_cnt == 4'd8);

	// bus levels for the phase about to be entered
	always_comb
	begin
		if (op_ready)
		begin
			nxt_kind = op_kind;
			nxt_phase = '0;
			nxt_ack = 1'b0;
			nxt_bit = op_byte.raw[7];
		end
		else if (phase != 2'd3)
		begin
			nxt_kind = kind_q;
			nxt_phase = phase + 1'b1;
			nxt_ack = (bit_cnt == 4'd8);
			nxt_bit = shreg[7];
		end
		else
		begin
			nxt_kind = kind_q;
			nxt_phase = '0;
			nxt_ack = (bit_cnt == 4'd7);
			nxt_bit = shreg[6];
		end
		case (nxt_kind)
			op_start:
			begin
				nxt_scl = !nxt_phase[1];
				nxt_oe = 1'b1;
				nxt_sda = (nxt_phase == 2'd0); // falls while scl high
			end
			op_stop:
			begin
				nxt_scl = (nxt_phase != 2'd0);
				nxt_oe = (nxt_phase != 2'd3); // let the pull-up hold it
				nxt_sda = nxt_phase[1]; // rises while scl high
			end
			default:
			begin
				nxt_scl = nxt_phase[0] ^ nxt_phase[1]; // low high high low
				nxt_oe = !nxt_ack;
				nxt_sda = nxt_bit;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (op_ready && op_go)
			shreg <= op_byte.raw;
		else if (!op_ready && phase == 2'd3)
			shreg <= shreg << 1; // msb first
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			kind_q <= op_start;
			phase <= '0;
			bit_cnt <= '0;
			op_ready <= 1'b1;
			op_done <= 1'b0;
			ack_ok <= 1'b0;
			scl <= 1'b1;
			sda_oe <= 1'b0;
			sda_out <= 1'b1;
		end
		else
		begin
			op_done <= 1'b0;
			if (op_ready)
			begin
				if (op_go)
				begin
					op_ready <= 1'b0;
					kind_q <= op_kind;
					phase <= nxt_phase;
					bit_cnt <= '0;
					scl <= nxt_scl;
					sda_oe <= nxt_oe;
					sda_out <= nxt_sda;
				end
			end
			else if (!last)
			begin
				phase <= nxt_phase;
				if (phase == 2'd3)
					bit_cnt <= bit_cnt + 1'b1;
				if (is_byte && bit_cnt == 4'd8 && phase == 2'd2)
					ack_ok <= !sda; // target pulls low to ack
				scl <= nxt_scl;
				sda_oe <= nxt_oe;
				sda_out <= nxt_sda;
			end
			else
			begin
				op_ready <= 1'b1;
				op_done <= 1'b1;
				if (is_byte && !ack_ok)
				begin
					scl <= 1'b1; // park the bus without a stop after a nack
					sda_oe <= 1'b0;
				end
			end
		end
	end

endmodule

// File: src/pattern_sequencer.sv
`timescale 1ns/10ps

module pattern_sequencer (
	input logic clk,
	input logic rst,
	input logic step,
	output expander_pkg::led_t led,
	output expander_pkg::byte_t pattern
);

	import expander_pkg::*;

	pat_idx_t idx;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			idx <= '0;
		else if (step)
		begin
			if (idx == pat_idx_t'(PAT_COUNT - 1))
				idx <= '0; // wrap after the last pattern
			else
				idx <= idx + 1'b1;
		end
	end

	always_comb
	begin
		led = led_t'(1) << idx; // one-hot view of the index
		pattern = PAT_DATA[idx];
	end

endmodule

// File: verif/i2c_target_model.sv
`timescale 1ns/10ps

module i2c_target_model (
	input logic clk,
	input logic rst,
	input logic scl,
	inout wire sda,
	input logic [2:0] nack_mask,
	output expander_pkg::byte_t rx_addr,
	output expander_pkg::byte_t rx_cmd,
	output expander_pkg::byte_t rx_data,
	output expander_pkg::byte_t rx_count,
	output int start_count,
	output int stop_count
);

	import expander_pkg::*;

	logic scl_q;
	logic sda_q;
	logic [3:0] bit_cnt;
	logic in_ack;
	logic ack_drive;
	byte_t shreg;

	assign sda = ack_drive ? 1'b0 : 1'bz; // open drain ack

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			scl_q <= 1'b1;
			sda_q <= 1'b1;
			bit_cnt <= '0;
			in_ack <= 1'b0;
			ack_drive <= 1'b0;
			shreg <= '0;
			rx_addr <= '0;
			rx_cmd <= '0;
			rx_data <= '0;
			rx_count <= '0;
			start_count <= 0;
			stop_count <= 0;
		end
		else
		begin
			scl_q <= scl;
			sda_q <= sda;
			if (scl_q && scl && sda_q && !sda)
			begin
				start_count <= start_count + 1; // sda falls while scl high
				rx_count <= '0;
				bit_cnt <= '0;
				in_ack <= 1'b0;
				ack_drive <= 1'b0;
			end
			else if (scl_q && scl && !sda_q && sda)
			begin
				stop_count <= stop_count + 1; // sda rises while scl high
				bit_cnt <= '0;
				in_ack <= 1'b0;
				ack_drive <= 1'b0;
			end
			else if (!scl_q && scl && bit_cnt < 4'd8)
			begin
				shreg <= {shreg[6:0], sda}; // msb first
				bit_cnt <= bit_cnt + 1'b1;
			end
			else if (scl_q && !scl)
			begin
				if (in_ack)
				begin
					in_ack <= 1'b0; // end of ack bit
					ack_drive <= 1'b0;
					bit_cnt <= '0;
				end
				else if (bit_cnt == 4'd8)
				begin
					in_ack <= 1'b1;
					ack_drive <= (rx_count > 8'd2) || !nack_mask[rx_count[1:0]];
					case (rx_count)
						8'd0: rx_addr <= shreg;
						8'd1: rx_cmd <= shreg;
						8'd2: rx_data <= shreg;
						default: ;
					endcase
					rx_count <= rx_count + 1'b1;
				end
			end
		end
	end

endmodule

// File: verif/tb_expander_top.sv
`timescale 1ns/10ps

module tb_expander_top;

	import expander_pkg::*;

	localparam int EN_HOLD = 8;
	localparam int BUTTON_HOLD = 8;
	localparam int RESET_CYCLES = 5;
	localparam int GAP = 4;
	localparam int SETTLE = 10;
	localparam int ROW_CYCLES = 200;
	localparam int ROWS = 10;

	typedef struct packed
	{
		logic [1:0] holds;
		logic short_en;
		logic [2:0] mask;
		byte_t addr;
		byte_t cmd;
		byte_t data;
		led_t led;
		logic nack;
	} row_t;

	// holds, short en pulse, nack mask (bit i = byte i), addr, cmd, data, led, nack_seen
	row_t stim [ROWS] = '{
		'{2'd0, 1'b1, 3'b010, 8'h40, 8'h03, 8'h00, 3'b001, 1'b1},
		'{2'd0, 1'b0, 3'b000, 8'h40, 8'h03, 8'h00, 3'b001, 1'b0},
		'{2'd0, 1'b1, 3'b000, 8'h40, 8'h01, 8'h01, 3'b001, 1'b0},
		'{2'd1, 1'b0, 3'b000, 8'h40, 8'h01, 8'h03, 3'b010, 1'b0},
		'{2'd1, 1'b0, 3'b000, 8'h40, 8'h01, 8'h07, 3'b100, 1'b0},
		'{2'd1, 1'b0, 3'b000, 8'h40, 8'h01, 8'h01, 3'b001, 1'b0},
		'{2'd0, 1'b0, 3'b010, 8'h40, 8'h01, 8'h00, 3'b001, 1'b1},
		'{2'd0, 1'b0, 3'b000, 8'h40, 8'h01, 8'h01, 3'b001, 1'b0},
		'{2'd1, 1'b0, 3'b001, 8'h40, 8'h00, 8'h00, 3'b010, 1'b1},
		'{2'd0, 1'b0, 3'b000, 8'h40, 8'h01, 8'h03, 3'b010, 1'b0}
	};

	logic clk;
	logic rst;
	logic en;
	logic button;
	logic scl;
	wire sda;
	led_t led;
	logic nack_seen;
	logic [2:0] nack_mask;
	byte_t rx_addr;
	byte_t rx_cmd;
	byte_t rx_data;
	byte_t rx_count;
	int start_count;
	int stop_count;
	int checks = 0;
	int errors = 0;

	pullup (sda);

	expander_top #(
		.EN_HOLD(EN_HOLD),
		.BUTTON_HOLD(BUTTON_HOLD),
		.TARGET_ADDR(7'h20)
	) u_expander_top (
		.clk(clk),
		.rst(rst),
		.en(en),
		.button(button),
		.scl(scl),
		.led(led),
		.nack_seen(nack_seen),
		.sda(sda)
	);

	i2c_target_model u_target (
		.clk(clk),
		.rst(rst),
		.scl(scl),
		.sda(sda),
		.nack_mask(nack_mask),
		.rx_addr(rx_addr),
		.rx_cmd(rx_cmd),
		.rx_data(rx_data),
		.rx_count(rx_count),
		.start_count(start_count),
		.stop_count(stop_count)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("[ERROR] %s: expected 0x%h, actual 0x%h", name, expected, actual);
		end
	endtask

	task automatic check_led(input string name, input led_t expected, input led_t actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic hold_en(input int cycles);
		en <= 1'b1;
		repeat (cycles) @(posedge clk);
		en <= 1'b0;
	endtask

	task automatic press_button();
		button <= 1'b1;
		repeat (BUTTON_HOLD) @(posedge clk);
		button <= 1'b0;
		repeat (GAP) @(posedge clk);
	endtask

	// bytes that reach the target before the first unacknowledged one
	function automatic int bytes_expected(input logic [2:0] mask);
		if (mask[0])
			return 1;
		else if (mask[1])
			return 2;
		else
			return 3;
	endfunction

	initial
	begin
		int limit;
		limit = ROWS * ROW_CYCLES + RESET_CYCLES;
		for (int i = 0; i < ROWS; i++)
			limit += int'(stim[i].holds) * (BUTTON_HOLD + GAP);
		repeat (limit) @(posedge clk);
		$display("watchdog expired after %0d cycles before the table finished", limit);
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		row_t row;
		int starts_before;
		int stops_before;
		int nbytes;
		rst = 1'b1;
		en = 1'b0;
		button = 1'b0;
		nack_mask = 3'b000;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		repeat (2) @(posedge clk);
		check_led("reset led", 3'b001, led);
		check_flag("reset scl", 1'b1, scl);
		check_flag("reset sda", 1'b1, sda);
		check_flag("reset nack_seen", 1'b0, nack_seen);

		for (int r = 0; r < ROWS; r++)
		begin
			row = stim[r];
			repeat (row.holds) press_button();
			nack_mask <= row.mask;
			if (row.short_en)
			begin
				starts_before = start_count;
				hold_en(EN_HOLD / 2); // too short to fire
				repeat (20) @(posedge clk);
				check_flag($sformatf("row %0d no start after short en", r), 1'b0,
					start_count != starts_before);
			end
			starts_before = start_count;
			stops_before = stop_count;
			hold_en(EN_HOLD);
			while (start_count == starts_before)
				@(posedge clk);
			check_flag($sformatf("row %0d nack_seen cleared at start", r), 1'b0, nack_seen);
			while (stop_count == stops_before && nack_seen !== 1'b1)
				@(posedge clk);
			repeat (SETTLE) @(posedge clk);

			nbytes = bytes_expected(row.mask);
			check_byte($sformatf("row %0d byte count", r), byte_t'(nbytes), rx_count);
			check_byte($sformatf("row %0d address", r), row.addr, rx_addr);
			if (nbytes > 1)
				check_byte($sformatf("row %0d command", r), row.cmd, rx_cmd);
			if (nbytes > 2)
				check_byte($sformatf("row %0d data", r), row.data, rx_data);
			check_flag($sformatf("row %0d stop seen", r), row.mask == 3'b000,
				stop_count != stops_before);
			check_led($sformatf("row %0d led", r), row.led, led);
			check_flag($sformatf("row %0d nack_seen", r), row.nack, nack_seen);
			check_flag($sformatf("row %0d scl idle", r), 1'b1, scl);
			check_flag($sformatf("row %0d sda idle", r), 1'b1, sda);
		end

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
